/* dcache_pkg.sv */
package dcache_pkg;

	// address and data widths
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;
	// a line is eight words, so 32 bytes of offset
	localparam int LINE_WORDS = 8;
	localparam int OFFSET_W = 5;
	// the 3-bit plru tree is built for exactly four ways
	localparam int WAYS = 4;
	// bus length field for a whole line, beats minus one
	localparam logic [7:0] BURST_LEN = 8'd7;

	typedef logic [WORD_W-1:0] word_t;
	// element 0 holds the lowest address of the line
	typedef word_t [LINE_WORDS-1:0] line_t;
	typedef logic [WAYS-1:0] way_mask_t;

	typedef struct packed {
		logic write;
		logic [ADDR_W-1:0] addr;
		word_t wdata;
		logic [3:0] wstrb;
	} cpu_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0] len;
	} mem_req_t;

	typedef struct packed {word_t data; logic last;} rd_beat_t;
	typedef struct packed {word_t data; logic [3:0] strb; logic last;} wr_beat_t;

endpackage

/* dcache_ctrl.sv */
module dcache_ctrl import dcache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic cpu_req_valid,
	input cpu_req_t cpu_req,
	input logic cpu_rsp_ready,
	input logic hit,
	input logic victim_dirty,
	input logic mem_rd_req_ready,
	input logic mem_rd_rsp_valid,
	input rd_beat_t mem_rd_rsp,
	input logic mem_wr_req_ready,
	input logic mem_wr_ready,
	input logic wb_last,
	output logic cpu_req_ready,
	output logic cpu_rsp_valid,
	output cpu_req_t req_q,
	output logic mem_rd_req_valid,
	output logic mem_rd_rsp_ready,
	output logic mem_wr_req_valid,
	output logic mem_wr_valid,
	output logic lookup_en,
	output logic evict_en,
	output logic fill_en,
	output logic write_en,
	output logic access_en
);

	// one-hot state bit positions
	localparam int S_IDLE = 0;
	localparam int S_LOOKUP = 1;
	localparam int S_READ = 2;
	localparam int S_RESPOND = 3;
	localparam int S_WRITE = 4;
	localparam int S_EVICT = 5;
	localparam int S_WB_REQ = 6;
	localparam int S_WB_DATA = 7;
	localparam int S_FILL_REQ = 8;
	localparam int S_FILL_DATA = 9;
	localparam int S_REFILL = 10;

	logic [10:0] state_q, state_d;

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= 11'(1 << S_IDLE);
		else
			state_q <= state_d;
	end

	// the request is held for the whole access, one in flight at most
	always_ff @(posedge clk) begin
		if (state_q[S_IDLE] && cpu_req_valid)
			req_q <= cpu_req;
	end

	always_comb begin
		state_d = '0;
		case (1'b1)
			state_q[S_IDLE]:
				state_d[cpu_req_valid ? S_LOOKUP : S_IDLE] = 1'b1;
			// tags compared against the latched address this cycle
			state_q[S_LOOKUP]:
				if (hit)
					state_d[req_q.write ? S_WRITE : S_READ] = 1'b1;
				else
					state_d[S_EVICT] = 1'b1;
			state_q[S_READ]:
				state_d[S_RESPOND] = 1'b1;
			state_q[S_RESPOND]:
				state_d[cpu_rsp_ready ? S_IDLE : S_RESPOND] = 1'b1;
			state_q[S_WRITE]:
				state_d[S_IDLE] = 1'b1;
			// clean victim skips straight to the line fetch
			state_q[S_EVICT]:
				state_d[victim_dirty ? S_WB_REQ : S_FILL_REQ] = 1'b1;
			state_q[S_WB_REQ]:
				state_d[mem_wr_req_ready ? S_WB_DATA : S_WB_REQ] = 1'b1;
			state_q[S_WB_DATA]:
				if (mem_wr_ready && wb_last)
					state_d[S_FILL_REQ] = 1'b1;
				else
					state_d[S_WB_DATA] = 1'b1;
			state_q[S_FILL_REQ]:
				state_d[mem_rd_req_ready ? S_FILL_DATA : S_FILL_REQ] = 1'b1;
			state_q[S_FILL_DATA]:
				if (mem_rd_rsp_valid && mem_rd_rsp.last)
					state_d[S_REFILL] = 1'b1;
				else
					state_d[S_FILL_DATA] = 1'b1;
			// after refill the access replays as a hit on the new way
			state_q[S_REFILL]:
				state_d[req_q.write ? S_WRITE : S_READ] = 1'b1;
			default:
				state_d[S_IDLE] = 1'b1;
		endcase
	end

	// handshakes straight from the state
	assign cpu_req_ready = state_q[S_IDLE];
	assign cpu_rsp_valid = state_q[S_RESPOND];
	assign mem_wr_req_valid = state_q[S_WB_REQ];
	assign mem_wr_valid = state_q[S_WB_DATA];
	assign mem_rd_req_valid = state_q[S_FILL_REQ];
	assign mem_rd_rsp_ready = state_q[S_FILL_DATA];

	// single-cycle strobes into the arrays and the plru
	assign lookup_en = state_q[S_LOOKUP];
	assign evict_en = state_q[S_EVICT];
	assign fill_en = state_q[S_REFILL];
	assign write_en = state_q[S_WRITE];
	assign access_en = state_q[S_READ] | state_q[S_WRITE];

endmodule

/* dcache_ways.sv */
module dcache_ways import dcache_pkg::*; #(
	parameter int SETS = 128
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] addr,
	input logic lookup_en,
	input logic evict_en,
	input way_mask_t victim,
	input logic fill_en,
	input line_t fill_line,
	input logic write_en,
	input word_t wdata,
	input logic [3:0] wstrb,
	output logic hit,
	output way_mask_t set_valid,
	output way_mask_t sel_way,
	output logic victim_dirty,
	output logic [ADDR_W-OFFSET_W-$clog2(SETS)-1:0] sel_tag,
	output line_t sel_line,
	output word_t sel_word
);

	localparam int SET_W = $clog2(SETS);
	localparam int TAG_W = ADDR_W - OFFSET_W - SET_W;

	logic [SET_W-1:0] set_idx;
	logic [TAG_W-1:0] tag;
	logic [2:0] word_idx;
	way_mask_t valid_q [SETS];
	way_mask_t dirty_q [SETS];
	logic [TAG_W-1:0] tag_q [SETS][WAYS];
	line_t data_q [SETS][WAYS];
	way_mask_t hit_way, sel_q;
	word_t merged;

	// address split into tag, set and word
	assign set_idx = addr[OFFSET_W +: SET_W];
	assign tag = addr[ADDR_W-1 -: TAG_W];
	assign word_idx = addr[OFFSET_W-1:2];

	always_comb begin
		for (int w = 0; w < WAYS; w++)
			hit_way[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == tag);
	end

	assign hit = |hit_way;
	assign set_valid = valid_q[set_idx];
	// only a valid and dirty victim needs a write-back
	assign victim_dirty = |(victim & valid_q[set_idx] & dirty_q[set_idx]);

	// hit way after lookup, overwritten by the victim on a miss
	always_ff @(posedge clk) begin
		if (rst)
			sel_q <= '0;
		else if (lookup_en)
			sel_q <= hit_way;
		else if (evict_en)
			sel_q <= victim;
	end

	assign sel_way = sel_q;

	always_comb begin
		sel_tag = '0;
		sel_line = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (sel_q[w]) begin
				sel_tag = tag_q[set_idx][w];
				sel_line = data_q[set_idx][w];
			end
		end
	end

	assign sel_word = sel_line[word_idx];

	// byte lanes without a strobe keep the cached value
	always_comb begin
		for (int b = 0; b < 4; b++)
			merged[8*b +: 8] = wstrb[b] ? wdata[8*b +: 8] : sel_word[8*b +: 8];
	end

	// refill leaves the line clean, a cpu write marks it dirty
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else if (fill_en) begin
			valid_q[set_idx] <= valid_q[set_idx] | sel_q;
			dirty_q[set_idx] <= dirty_q[set_idx] & ~sel_q;
		end else if (write_en) begin
			dirty_q[set_idx] <= dirty_q[set_idx] | sel_q;
		end
	end

	always_ff @(posedge clk) begin
		for (int w = 0; w < WAYS; w++) begin
			if (sel_q[w] && fill_en) begin
				tag_q[set_idx][w] <= tag;
				data_q[set_idx][w] <= fill_line;
			end else if (sel_q[w] && write_en) begin
				data_q[set_idx][w][word_idx] <= merged;
			end
		end
	end

endmodule

/* plru_policy.sv */
module plru_policy import dcache_pkg::*; #(
	parameter int SETS = 128
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] addr,
	input way_mask_t set_valid,
	input logic access_en,
	input way_mask_t sel_way,
	output way_mask_t victim
);

	localparam int SET_W = $clog2(SETS);

	logic [SET_W-1:0] set_idx;
	// bit 0 is the root, bit 1 the way0/way1 node, bit 2 the way2/way3 node
	logic [2:0] tree_q [SETS];
	logic [2:0] tree;

	assign set_idx = addr[OFFSET_W +: SET_W];
	assign tree = tree_q[set_idx];

	// empty ways are filled lowest first, the tree only decides in a full set
	always_comb begin
		if (!set_valid[0])
			victim = 4'b0001;
		else if (!set_valid[1])
			victim = 4'b0010;
		else if (!set_valid[2])
			victim = 4'b0100;
		else if (!set_valid[3])
			victim = 4'b1000;
		else if (!tree[0])
			victim = tree[1] ? 4'b0010 : 4'b0001;
		else
			victim = tree[2] ? 4'b1000 : 4'b0100;
	end

	// each node is pointed away from the side just touched
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < SETS; s++)
				tree_q[s] <= '0;
		end else if (access_en) begin
			if (sel_way[0] || sel_way[1]) begin
				tree_q[set_idx][0] <= 1'b1;
				tree_q[set_idx][1] <= sel_way[0];
			end else begin
				tree_q[set_idx][0] <= 1'b0;
				tree_q[set_idx][2] <= sel_way[2];
			end
		end
	end

endmodule

/* line_buffer.sv */
module line_buffer import dcache_pkg::*; #(
	parameter int SETS = 128
) (
	input logic clk,
	input logic rst,
	input logic [ADDR_W-1:0] addr,
	input logic [ADDR_W-OFFSET_W-$clog2(SETS)-1:0] sel_tag,
	input line_t sel_line,
	input logic mem_rd_rsp_valid,
	input logic mem_rd_rsp_ready,
	input rd_beat_t mem_rd_rsp,
	input logic mem_wr_req_valid,
	input logic mem_wr_req_ready,
	input logic mem_wr_valid,
	input logic mem_wr_ready,
	output line_t fill_line,
	output mem_req_t mem_rd_req,
	output mem_req_t mem_wr_req,
	output wr_beat_t mem_wr,
	output logic wb_last
);

	localparam int SET_W = $clog2(SETS);

	line_t fill_q, wb_q;
	logic [2:0] beat_q;

	// beats arrive word 0 first, shifting in from the top
	always_ff @(posedge clk) begin
		if (mem_rd_rsp_valid && mem_rd_rsp_ready)
			fill_q <= {mem_rd_rsp.data, fill_q[LINE_WORDS-1:1]};
	end

	assign fill_line = fill_q;

	// victim line captured as the write request goes out
	always_ff @(posedge clk) begin
		if (mem_wr_req_valid && mem_wr_req_ready)
			wb_q <= sel_line;
		else if (mem_wr_valid && mem_wr_ready)
			wb_q <= wb_q >> WORD_W;
	end

	always_ff @(posedge clk) begin
		if (rst || (mem_wr_req_valid && mem_wr_req_ready))
			beat_q <= '0;
		else if (mem_wr_valid && mem_wr_ready)
			beat_q <= beat_q + 3'd1;
	end

	assign wb_last = (beat_q == 3'(LINE_WORDS - 1));
	assign mem_wr = '{data: wb_q[0], strb: 4'hf, last: wb_last};

	// fetch the line holding the request, write back the victim's own line
	assign mem_rd_req = '{addr: {addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)}, len: BURST_LEN};
	assign mem_wr_req = '{addr: {sel_tag, addr[OFFSET_W +: SET_W], OFFSET_W'(0)},
		len: BURST_LEN};

endmodule

/* dcache_top.sv */
module dcache_top import dcache_pkg::*; #(
	parameter int SETS = 128
) (
	input logic clk,
	input logic rst,
	// cpu request and response
	input logic cpu_req_valid,
	input cpu_req_t cpu_req,
	output logic cpu_req_ready,
	output logic cpu_rsp_valid,
	output word_t cpu_rsp_data,
	input logic cpu_rsp_ready,
	// memory read channels
	output logic mem_rd_req_valid,
	output mem_req_t mem_rd_req,
	input logic mem_rd_req_ready,
	input logic mem_rd_rsp_valid,
	input rd_beat_t mem_rd_rsp,
	output logic mem_rd_rsp_ready,
	// memory write channels
	output logic mem_wr_req_valid,
	output mem_req_t mem_wr_req,
	input logic mem_wr_req_ready,
	output logic mem_wr_valid,
	output wr_beat_t mem_wr,
	input logic mem_wr_ready
);

	localparam int TAG_W = ADDR_W - OFFSET_W - $clog2(SETS);

	cpu_req_t req_q;
	logic hit, victim_dirty, wb_last;
	logic lookup_en, evict_en, fill_en, write_en, access_en;
	way_mask_t set_valid, sel_way, victim;
	logic [TAG_W-1:0] sel_tag;
	line_t sel_line, fill_line;

	dcache_ctrl u_ctrl (.*);

	dcache_ways #(.SETS(SETS)) u_ways (.*, .addr(req_q.addr), .wdata(req_q.wdata),
		.wstrb(req_q.wstrb), .sel_word(cpu_rsp_data));

	plru_policy #(.SETS(SETS)) u_plru (.*, .addr(req_q.addr));

	line_buffer #(.SETS(SETS)) u_lbuf (.*, .addr(req_q.addr));

endmodule

/* dcache_assertions.sv */
module dcache_assertions import dcache_pkg::*; (
	input logic clk,
	input logic rst,
	input logic mem_rd_req_valid,
	input logic mem_rd_req_ready,
	input mem_req_t mem_rd_req,
	input logic mem_wr_req_valid,
	input logic mem_wr_req_ready,
	input mem_req_t mem_wr_req,
	input logic mem_wr_valid,
	input logic mem_wr_ready,
	input wr_beat_t mem_wr
);

	// every request on either channel covers a whole line
	rd_len: assert property (@(posedge clk) disable iff (rst)
		mem_rd_req_valid |-> mem_rd_req.len == BURST_LEN)
		else $error("read request length is not a full line");
	wr_len: assert property (@(posedge clk) disable iff (rst)
		mem_wr_req_valid |-> mem_wr_req.len == BURST_LEN)
		else $error("write request length is not a full line");

	// write-back always sends whole words
	wr_strb: assert property (@(posedge clk) disable iff (rst)
		mem_wr_valid |-> mem_wr.strb == 4'hf)
		else $error("write beat with partial strobe");

	// a raised valid keeps its payload until the transfer
	rd_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_rd_req_valid && !mem_rd_req_ready |=> mem_rd_req_valid && $stable(mem_rd_req))
		else $error("read request dropped or changed before ready");
	wr_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_wr_req_valid && !mem_wr_req_ready |=> mem_wr_req_valid && $stable(mem_wr_req))
		else $error("write request dropped or changed before ready");
	wr_hold: assert property (@(posedge clk) disable iff (rst)
		mem_wr_valid && !mem_wr_ready |=> mem_wr_valid && $stable(mem_wr))
		else $error("write beat dropped or changed before ready");

endmodule

bind dcache_top dcache_assertions u_bus_assertions (.*);

/* dcache_checker.sv */
module dcache_checker import dcache_pkg::*; #(
	parameter logic [31:0] PATTERN = 32'h0
) (
	input logic clk,
	input logic rst,
	input logic cpu_req_valid,
	input logic cpu_req_ready,
	input cpu_req_t cpu_req,
	input logic cpu_rsp_valid,
	input logic cpu_rsp_ready,
	input word_t cpu_rsp_data,
	input logic mem_rd_req_valid,
	input logic mem_rd_req_ready,
	input mem_req_t mem_rd_req,
	input logic mem_rd_rsp_ready,
	input logic mem_wr_req_valid,
	input logic mem_wr_req_ready,
	input mem_req_t mem_wr_req,
	input logic mem_wr_valid,
	input logic mem_wr_ready,
	input wr_beat_t mem_wr,
	input logic op_done,
	input logic exp_miss,
	input logic exp_wb,
	input logic [31:0] exp_wb_addr,
	output int errors
);

	// only words written by the cpu are kept, the rest follow the fill pattern
	word_t shadow [int unsigned];
	cpu_req_t req;
	logic [31:0] wb_addr;
	logic rst_q;
	int err_count = 0;
	int n_rd = 0;
	int n_wr = 0;
	int beats = 0;
	int beat = 0;

	assign errors = err_count;

	function automatic word_t expect_word(input logic [31:0] a);
		logic [31:0] w;
		w = {a[31:2], 2'b00};
		if (shadow.exists(w))
			return shadow[w];
		return w ^ PATTERN;
	endfunction

	task automatic report_mismatch(input string msg);
		err_count++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	always @(posedge clk) begin
		word_t w;
		rst_q <= rst;
		// control outputs go quiet once reset has been seen
		if (rst_q && (!cpu_req_ready || cpu_rsp_valid || mem_rd_req_valid
				|| mem_rd_rsp_ready || mem_wr_req_valid || mem_wr_valid))
			report_mismatch("control outputs not idle in reset");
		// accepted writes update the shadow with their strobed bytes only
		if (cpu_req_valid && cpu_req_ready) begin
			req = cpu_req;
			if (cpu_req.write) begin
				w = expect_word(cpu_req.addr);
				for (int b = 0; b < 4; b++)
					if (cpu_req.wstrb[b])
						w[8*b +: 8] = cpu_req.wdata[8*b +: 8];
				shadow[{cpu_req.addr[31:2], 2'b00}] = w;
			end
		end
		if (cpu_rsp_valid && cpu_rsp_ready && cpu_rsp_data !== expect_word(req.addr))
			report_mismatch($sformatf("read %h returned %h, expected %h",
				req.addr, cpu_rsp_data, expect_word(req.addr)));
		// refill always fetches the line of the pending request
		if (mem_rd_req_valid && mem_rd_req_ready) begin
			n_rd++;
			if (mem_rd_req.addr !== {req.addr[31:5], 5'b0} || mem_rd_req.len !== BURST_LEN)
				report_mismatch($sformatf("read request %h len %0d for access %h",
					mem_rd_req.addr, mem_rd_req.len, req.addr));
		end
		if (mem_wr_req_valid && mem_wr_req_ready) begin
			n_wr++;
			wb_addr = mem_wr_req.addr;
			beat = 0;
			if (mem_wr_req.addr !== exp_wb_addr || mem_wr_req.len !== BURST_LEN)
				report_mismatch($sformatf("write-back to %h, expected %h",
					mem_wr_req.addr, exp_wb_addr));
		end
		// victim words leave in address order, last on the eighth
		if (mem_wr_valid && mem_wr_ready) begin
			if (mem_wr.data !== expect_word(wb_addr + 4*beat) || mem_wr.strb !== 4'hf
					|| mem_wr.last !== (beat == LINE_WORDS - 1))
				report_mismatch($sformatf("write-back beat %0d data %h last %b", beat,
					mem_wr.data, mem_wr.last));
			beat++;
			beats++;
		end
		if (op_done) begin
			if (n_rd != int'(exp_miss) || n_wr != int'(exp_wb) || beats != 8*int'(exp_wb))
				report_mismatch($sformatf("access %h made %0d fills, %0d write-backs, %0d beats",
					req.addr, n_rd, n_wr, beats));
			n_rd = 0;
			n_wr = 0;
			beats = 0;
		end
	end

endmodule

/* tb_dcache.sv */
module tb_dcache import dcache_pkg::*; ();

	localparam logic [31:0] PATTERN = 32'hc3a5_5a3c;
	localparam int NUM_OPS = 15;
	localparam int TIMEOUT = 500;

	// one cpu operation and what it should cost on the bus
	typedef struct packed {
		logic write;
		logic [31:0] addr;
		word_t data;
		logic [3:0] strb;
		logic miss;
		logic wb;
		logic [31:0] wb_addr;
	} op_t;

	logic clk;
	logic rst = 1'b1;
	logic cpu_req_valid = 1'b0;
	cpu_req_t cpu_req = '0;
	logic cpu_req_ready, cpu_rsp_valid;
	word_t cpu_rsp_data;
	logic cpu_rsp_ready = 1'b0;
	logic mem_rd_req_valid, mem_rd_rsp_ready, mem_wr_req_valid, mem_wr_valid;
	mem_req_t mem_rd_req, mem_wr_req;
	wr_beat_t mem_wr;
	logic mem_rd_req_ready = 1'b0;
	logic mem_rd_rsp_valid = 1'b0;
	rd_beat_t mem_rd_rsp = '0;
	logic mem_wr_req_ready = 1'b0;
	logic mem_wr_ready = 1'b0;
	logic op_done = 1'b0;
	logic exp_miss = 1'b0;
	logic exp_wb = 1'b0;
	logic [31:0] exp_wb_addr = '0;
	int errors;
	int timeouts = 0;
	op_t ops [NUM_OPS];
	word_t backing [int unsigned];
	logic [31:0] rd_addr, wr_addr;
	int rd_left = 0;

	dcache_top UUT (.*);

	dcache_checker #(.PATTERN(PATTERN)) u_checker (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic word_t mem_word(input logic [31:0] a);
		if (backing.exists(a))
			return backing[a];
		return a ^ PATTERN;
	endfunction

	// memory model, bus transfers sampled at the edge, new values 2 units later
	always @(posedge clk) begin
		logic rd_beat_fire;
		rd_beat_fire = mem_rd_rsp_valid && mem_rd_rsp_ready;
		if (mem_rd_req_valid && mem_rd_req_ready) begin
			rd_addr = mem_rd_req.addr;
			rd_left = LINE_WORDS;
		end
		if (rd_beat_fire) begin
			rd_addr += 4;
			rd_left--;
		end
		if (mem_wr_req_valid && mem_wr_req_ready)
			wr_addr = mem_wr_req.addr;
		if (mem_wr_valid && mem_wr_ready) begin
			backing[wr_addr] = mem_wr.data;
			wr_addr += 4;
		end
		#2;
		mem_rd_req_ready = ($urandom % 4) != 0;
		mem_wr_req_ready = ($urandom % 4) != 0;
		mem_wr_ready = ($urandom % 3) != 0;
		cpu_rsp_ready = ($urandom % 3) != 0;
		// a pending beat stays put until taken
		if (!mem_rd_rsp_valid || rd_beat_fire) begin
			mem_rd_rsp_valid = rd_left > 0 && ($urandom % 3) != 0;
			mem_rd_rsp = '{data: mem_word(rd_addr), last: rd_left == 1};
		end
	end

	task automatic note_timeout(input string msg);
		timeouts++;
		$display("timeout at %0t: %s", $time, msg);
	endtask

	task automatic run_op(input op_t op);
		int n;
		exp_miss = op.miss;
		exp_wb = op.wb;
		exp_wb_addr = op.wb_addr;
		cpu_req = '{write: op.write, addr: op.addr, wdata: op.data, wstrb: op.strb};
		cpu_req_valid = 1'b1;
		n = 0;
		while (n < TIMEOUT) begin
			@(posedge clk);
			if (cpu_req_ready)
				break;
			n++;
		end
		if (n == TIMEOUT) begin
			note_timeout("request was never accepted");
			return;
		end
		#2 cpu_req_valid = 1'b0;
		// a read ends on its response, a write when the cache is ready again
		n = 0;
		while (n < TIMEOUT) begin
			@(posedge clk);
			if (op.write ? cpu_req_ready : (cpu_rsp_valid && cpu_rsp_ready))
				break;
			n++;
		end
		if (n == TIMEOUT) begin
			note_timeout("access did not complete");
			return;
		end
		#2 op_done = 1'b1;
		@(posedge clk);
		#2 op_done = 1'b0;
	endtask

	initial begin
		void'($urandom(13));
		// all in set 2 except the last pair, five tags contend for four ways
		ops = '{
			'{1'b0, 32'h0000_0040, 32'h0000_0000, 4'h0, 1'b1, 1'b0, 32'h0},
			'{1'b0, 32'h0000_0044, 32'h0000_0000, 4'h0, 1'b0, 1'b0, 32'h0},
			'{1'b1, 32'h0000_0048, 32'haabb_ccdd, 4'h3, 1'b0, 1'b0, 32'h0},
			'{1'b0, 32'h0000_0048, 32'h0000_0000, 4'h0, 1'b0, 1'b0, 32'h0},
			'{1'b1, 32'h0000_1040, 32'h1111_2222, 4'hf, 1'b1, 1'b0, 32'h0},
			'{1'b1, 32'h0000_2044, 32'h3344_5566, 4'h4, 1'b1, 1'b0, 32'h0},
			'{1'b0, 32'h0000_3040, 32'h0000_0000, 4'h0, 1'b1, 1'b0, 32'h0},
			'{1'b0, 32'h0000_4040, 32'h0000_0000, 4'h0, 1'b1, 1'b1, 32'h0000_0040},
			'{1'b0, 32'h0000_0048, 32'h0000_0000, 4'h0, 1'b1, 1'b1, 32'h0000_2040},
			'{1'b0, 32'h0000_2044, 32'h0000_0000, 4'h0, 1'b1, 1'b1, 32'h0000_1040},
			'{1'b0, 32'h0000_1040, 32'h0000_0000, 4'h0, 1'b1, 1'b0, 32'h0},
			'{1'b1, 32'h0000_5040, 32'h7788_99aa, 4'h8, 1'b1, 1'b0, 32'h0},
			'{1'b0, 32'h0000_5040, 32'h0000_0000, 4'h0, 1'b0, 1'b0, 32'h0},
			'{1'b1, 32'h0000_0104, 32'h0bad_f00d, 4'h6, 1'b1, 1'b0, 32'h0},
			'{1'b0, 32'h0000_0104, 32'h0000_0000, 4'h0, 1'b0, 1'b0, 32'h0}
		};
		repeat (4) @(posedge clk);
		#2 rst = 1'b0;
		for (int i = 0; i < NUM_OPS && timeouts == 0; i++)
			run_op(ops[i]);
		repeat (4) @(posedge clk);
		$display("%0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* sources.f */
dcache_pkg.sv
dcache_ctrl.sv
dcache_ways.sv
plru_policy.sv
line_buffer.sv
dcache_top.sv
dcache_assertions.sv
dcache_checker.sv
tb_dcache.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module tb_dcache -f sources.f
	./obj_dir/Vtb_dcache | awk '{ print } /^Simulation passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
